//--- verilog/icb_fab_pkg.sv
/*
  Shared widths, target count and payload types of the 1-to-4 bus fabric.
  Every fabric module and the testbench refer to these by scoped name.
*/

package icb_fab_pkg;

  // Bus widths
  localparam int AW = 32;
  localparam int DW = 32;

  // Mapped targets, the default target sits at index N_TGT
  localparam int N_TGT = 4;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } icb_size_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } split_state_e;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  // Command channel, valid and ready travel beside it
  typedef struct packed {
    logic [AW-1:0]   addr;
    logic            read;
    logic [DW-1:0]   wdata;
    logic [DW/8-1:0] wmask;
    icb_size_e       size;
  } icb_cmd_t;

  // Response channel
  typedef struct packed {
    logic          err;
    logic [DW-1:0] rdata;
  } icb_rsp_t;

endpackage

//--- verilog/icb_addr_decode.sv
/*
  Address decoder of the bus fabric. Compares the command address with the
  region of each enabled target and returns a one-hot select whose top bit
  picks the default target. Purely combinational.
*/

module icb_addr_decode #(
  parameter logic [icb_fab_pkg::N_TGT-1:0][icb_fab_pkg::AW-1:0] BASE_ADDR = {
    32'h0000_4000, 32'h0000_3000, 32'h0000_2000, 32'h0000_1000
  },
  parameter logic [icb_fab_pkg::N_TGT-1:0][7:0] REGION_LSB = {icb_fab_pkg::N_TGT{8'd12}}
) (
  input  logic [icb_fab_pkg::AW-1:0]  i_addr,
  input  logic [icb_fab_pkg::N_TGT-1:0] i_tgt_en,
  output logic [icb_fab_pkg::N_TGT:0]   o_sel
);

  logic [icb_fab_pkg::N_TGT-1:0] hit;

  // Region match, bits below REGION_LSB are the offset inside the region
  for (genvar t = 0; t < icb_fab_pkg::N_TGT; t++) begin : g_match
    localparam logic [icb_fab_pkg::AW-1:0] REGION_MASK =
      {icb_fab_pkg::AW{1'b1}} << REGION_LSB[t];

    assign hit[t] = i_tgt_en[t] &
                    ((i_addr & REGION_MASK) == (BASE_ADDR[t] & REGION_MASK));
  end

  // Keep the select one-hot when regions overlap
  always_comb begin
    logic taken;
    taken = 1'b0;
    o_sel = '0;
    for (int t = 0; t < icb_fab_pkg::N_TGT; t++) begin
      if (hit[t] && !taken) begin
        o_sel[t] = 1'b1;
        taken    = 1'b1;
      end
    end
    // Nothing mapped here, so the default target answers
    o_sel[icb_fab_pkg::N_TGT] = ~taken;
  end

endmodule

//--- verilog/icb_split_ctrl.sv
/*
  Split controller of the bus fabric. Counts outstanding transactions,
  remembers which target they went to and only lets a new command pass when
  it goes to that same target and the count has room left.
*/

module icb_split_ctrl #(
  parameter int MAX_OUTS = 2
) (
  input  logic                        clk,
  input  logic                        i_rst,
  input  logic                        i_cmd_valid,
  input  logic [icb_fab_pkg::N_TGT:0] i_sel,
  input  logic                        i_cmd_ready_sel,
  input  logic                        i_rsp_valid_sel,
  input  logic                        i_rsp_ready,
  output logic                        o_cmd_go,
  output logic [icb_fab_pkg::N_TGT:0] o_rsp_sel
);

  localparam int CW = $clog2(MAX_OUTS + 1);

  icb_fab_pkg::split_state_e state;
  icb_fab_pkg::split_state_e state_nxt;

  logic [CW-1:0]               outs_cnt;
  logic [CW-1:0]               cnt_nxt;
  logic [icb_fab_pkg::N_TGT:0] tgt_ptr;

  logic cmd_hsk;
  logic rsp_hsk;
  logic same_tgt;
  logic has_room;

  assign cmd_hsk = i_cmd_valid & i_cmd_ready_sel;
  assign rsp_hsk = i_rsp_valid_sel & i_rsp_ready;

  ////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////

  assign same_tgt = (i_sel == tgt_ptr);
  assign has_room = (outs_cnt < CW'(MAX_OUTS));

  // Never two different targets outstanding at once
  assign o_cmd_go = (state == icb_fab_pkg::ST_IDLE) | (same_tgt & has_room);

  // When idle the fresh select routes a zero-cycle response
  assign o_rsp_sel = (state == icb_fab_pkg::ST_IDLE) ? i_sel : tgt_ptr;

  ////////////////////////////////////////
  // Outstanding tracking
  ////////////////////////////////////////

  always_comb begin
    case ({cmd_hsk, rsp_hsk})
      2'b10:   cnt_nxt = outs_cnt + CW'(1);
      2'b01:   cnt_nxt = outs_cnt - CW'(1);
      // Both or neither, the count holds
      default: cnt_nxt = outs_cnt;
    endcase
  end

  always_comb begin
    if (cnt_nxt == '0) begin
      state_nxt = icb_fab_pkg::ST_IDLE;
    end else begin
      state_nxt = icb_fab_pkg::ST_BUSY;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      outs_cnt <= '0;
      state    <= icb_fab_pkg::ST_IDLE;
      tgt_ptr  <= '0;
    end else begin
      outs_cnt <= cnt_nxt;
      state    <= state_nxt;
      if (cmd_hsk) begin
        tgt_ptr <= i_sel;
      end
    end
  end

endmodule

//--- verilog/icb_cmd_route.sv
/*
  Command router of the bus fabric. Fans the initiator command out to the
  selected lane only and returns that lane's ready. Combinational.
*/

module icb_cmd_route (
  input  logic                                          i_cmd_valid,
  input  icb_fab_pkg::icb_cmd_t                         i_cmd,
  input  logic [icb_fab_pkg::N_TGT:0]                   i_sel,
  input  logic                                          i_cmd_go,
  output logic [icb_fab_pkg::N_TGT:0]                   o_tgt_cmd_valid,
  output icb_fab_pkg::icb_cmd_t [icb_fab_pkg::N_TGT-1:0] o_tgt_cmd,
  input  logic [icb_fab_pkg::N_TGT:0]                   i_tgt_cmd_ready,
  output logic                                          o_cmd_ready,
  output logic                                          o_cmd_ready_sel
);

  logic sel_ready;

  // Valid only on the selected lane and only when the controller agrees
  assign o_tgt_cmd_valid = {(icb_fab_pkg::N_TGT + 1){i_cmd_valid & i_cmd_go}} & i_sel;

  // Unselected lanes see an all-zero payload
  always_comb begin
    for (int t = 0; t < icb_fab_pkg::N_TGT; t++) begin
      o_tgt_cmd[t] = i_sel[t] ? i_cmd : '0;
    end
  end

  assign sel_ready = |(i_sel & i_tgt_cmd_ready) & i_cmd_go;

  assign o_cmd_ready     = sel_ready;
  assign o_cmd_ready_sel = sel_ready;

endmodule

//--- verilog/icb_rsp_mux.sv
/*
  Response multiplexer of the bus fabric, which also holds the default
  target. The default target answers in the command cycle with an error and
  zero data; mapped targets are forwarded on the lane named by i_rsp_sel.
*/

module icb_rsp_mux (
  input  logic [icb_fab_pkg::N_TGT:0]                   i_rsp_sel,
  input  logic                                          i_deft_cmd_valid,
  input  logic [icb_fab_pkg::N_TGT-1:0]                 i_tgt_rsp_valid,
  input  icb_fab_pkg::icb_rsp_t [icb_fab_pkg::N_TGT-1:0] i_tgt_rsp,
  input  logic                                          i_rsp_ready,
  output logic                                          o_rsp_valid,
  output icb_fab_pkg::icb_rsp_t                         o_rsp,
  output logic [icb_fab_pkg::N_TGT-1:0]                 o_tgt_rsp_ready,
  output logic                                          o_deft_cmd_ready
);

  localparam icb_fab_pkg::icb_rsp_t DEFT_RSP = '{err: 1'b1, rdata: '0};

  logic [icb_fab_pkg::N_TGT:0]                   all_valid;
  icb_fab_pkg::icb_rsp_t [icb_fab_pkg::N_TGT:0]  all_rsp;
  logic [$bits(icb_fab_pkg::icb_rsp_t)-1:0]      rsp_or;
  logic                                          valid_or;

  ////////////////////////////////////////
  // Default target
  ////////////////////////////////////////

  // Zero-cycle answer, so it can take a command only when the
  // initiator can take the response
  assign o_deft_cmd_ready = i_rsp_ready;

  assign all_valid = {i_deft_cmd_valid, i_tgt_rsp_valid};
  assign all_rsp   = {DEFT_RSP, i_tgt_rsp};

  ////////////////////////////////////////
  // Response select
  ////////////////////////////////////////

  // AND-OR mux over the one-hot select
  always_comb begin
    valid_or = 1'b0;
    rsp_or   = '0;
    for (int i = 0; i <= icb_fab_pkg::N_TGT; i++) begin
      valid_or = valid_or | (i_rsp_sel[i] & all_valid[i]);
      if (i_rsp_sel[i]) begin
        rsp_or = rsp_or | all_rsp[i];
      end
    end
  end

  assign o_rsp_valid = valid_or;
  assign o_rsp       = rsp_or;

  // Back-pressure reaches only the lane being served
  assign o_tgt_rsp_ready = {icb_fab_pkg::N_TGT{i_rsp_ready}}
                         & i_rsp_sel[icb_fab_pkg::N_TGT-1:0];

endmodule

//--- verilog/icb_bus_1to4.sv
/*
  Bus fabric with one initiator and four address-decoded targets plus a
  built-in default target. Commands pass without a register stage; the split
  controller keeps all outstanding transactions on a single target.
*/

module icb_bus_1to4 #(
  parameter int MAX_OUTS = 2,
  parameter logic [icb_fab_pkg::N_TGT-1:0][icb_fab_pkg::AW-1:0] BASE_ADDR = {
    32'h0000_4000, 32'h0000_3000, 32'h0000_2000, 32'h0000_1000
  },
  parameter logic [icb_fab_pkg::N_TGT-1:0][7:0] REGION_LSB = {icb_fab_pkg::N_TGT{8'd12}}
) (
  input  logic                                          clk,
  input  logic                                          i_rst,
  input  logic [icb_fab_pkg::N_TGT-1:0]                 i_tgt_en,

  // Initiator side
  input  logic                                          i_cmd_valid,
  output logic                                          o_cmd_ready,
  input  icb_fab_pkg::icb_cmd_t                         i_cmd,
  output logic                                          o_rsp_valid,
  input  logic                                          i_rsp_ready,
  output icb_fab_pkg::icb_rsp_t                         o_rsp,

  // Target side, one lane per mapped target
  output logic [icb_fab_pkg::N_TGT-1:0]                 o_tgt_cmd_valid,
  input  logic [icb_fab_pkg::N_TGT-1:0]                 i_tgt_cmd_ready,
  output icb_fab_pkg::icb_cmd_t [icb_fab_pkg::N_TGT-1:0] o_tgt_cmd,
  input  logic [icb_fab_pkg::N_TGT-1:0]                 i_tgt_rsp_valid,
  output logic [icb_fab_pkg::N_TGT-1:0]                 o_tgt_rsp_ready,
  input  icb_fab_pkg::icb_rsp_t [icb_fab_pkg::N_TGT-1:0] i_tgt_rsp
);

  logic [icb_fab_pkg::N_TGT:0] sel;
  logic [icb_fab_pkg::N_TGT:0] rsp_sel;
  logic [icb_fab_pkg::N_TGT:0] lane_cmd_valid;
  logic [icb_fab_pkg::N_TGT:0] lane_cmd_ready;

  logic cmd_go;
  logic cmd_ready_sel;
  logic deft_cmd_valid;
  logic deft_cmd_ready;

  ////////////////////////////////////////
  // Decode and control
  ////////////////////////////////////////

  icb_addr_decode #(
    .BASE_ADDR  (BASE_ADDR),
    .REGION_LSB (REGION_LSB)
  ) u_addr_decode (
    .i_addr   (i_cmd.addr),
    .i_tgt_en (i_tgt_en),
    .o_sel    (sel)
  );

  icb_split_ctrl #(
    .MAX_OUTS (MAX_OUTS)
  ) u_split_ctrl (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_cmd_valid     (i_cmd_valid),
    .i_sel           (sel),
    .i_cmd_ready_sel (cmd_ready_sel),
    .i_rsp_valid_sel (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .o_cmd_go        (cmd_go),
    .o_rsp_sel       (rsp_sel)
  );

  ////////////////////////////////////////
  // Command and response datapath
  ////////////////////////////////////////

  // Top lane belongs to the default target
  assign lane_cmd_ready  = {deft_cmd_ready, i_tgt_cmd_ready};
  assign o_tgt_cmd_valid = lane_cmd_valid[icb_fab_pkg::N_TGT-1:0];
  assign deft_cmd_valid  = lane_cmd_valid[icb_fab_pkg::N_TGT];

  icb_cmd_route u_cmd_route (
    .i_cmd_valid     (i_cmd_valid),
    .i_cmd           (i_cmd),
    .i_sel           (sel),
    .i_cmd_go        (cmd_go),
    .o_tgt_cmd_valid (lane_cmd_valid),
    .o_tgt_cmd       (o_tgt_cmd),
    .i_tgt_cmd_ready (lane_cmd_ready),
    .o_cmd_ready     (o_cmd_ready),
    .o_cmd_ready_sel (cmd_ready_sel)
  );

  icb_rsp_mux u_rsp_mux (
    .i_rsp_sel        (rsp_sel),
    .i_deft_cmd_valid (deft_cmd_valid),
    .i_tgt_rsp_valid  (i_tgt_rsp_valid),
    .i_tgt_rsp        (i_tgt_rsp),
    .i_rsp_ready      (i_rsp_ready),
    .o_rsp_valid      (o_rsp_valid),
    .o_rsp            (o_rsp),
    .o_tgt_rsp_ready  (o_tgt_rsp_ready),
    .o_deft_cmd_ready (deft_cmd_ready)
  );

endmodule

//--- bench/icb_target_model.sv
/*
  Behavioral bus target for the fabric testbench. Accepts commands unless
  stalled, answers each one LAT cycles later in command order with the
  address XOR KEY as read data. LAT of 0 answers in the command cycle.
*/

module icb_target_model #(
  parameter int          LAT = 1,
  parameter logic [31:0] KEY = 32'h0
) (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_stall,
  input  logic                  i_cmd_valid,
  output logic                  o_cmd_ready,
  input  icb_fab_pkg::icb_cmd_t i_cmd,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output icb_fab_pkg::icb_rsp_t o_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] data_mem [4];
  int          due_mem  [4];
  logic [1:0]  rd_ptr;
  logic [1:0]  wr_ptr;
  logic [2:0]  cnt;
  int          cyc;
  logic        head_ok;
  logic        bypass;
  logic        push;
  logic        pop;

  assign o_cmd_ready = !i_stall && (cnt < 3'd4);

  always_comb begin
    head_ok     = (cnt != 3'd0) && (due_mem[rd_ptr] <= cyc);
    // Zero latency answers straight from the command
    bypass      = (LAT == 0) && (cnt == 3'd0) && i_cmd_valid && o_cmd_ready;
    o_rsp_valid = head_ok || bypass;
    o_rsp.err   = 1'b0;
    o_rsp.rdata = head_ok ? data_mem[rd_ptr] : (i_cmd.addr ^ KEY);
    push        = i_cmd_valid && o_cmd_ready && !(bypass && i_rsp_ready);
    pop         = head_ok && i_rsp_ready;
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      cnt    <= '0;
      cyc    <= 0;
    end else begin
      cyc <= cyc + 1;
      if (push) begin
        data_mem[wr_ptr] <= i_cmd.addr ^ KEY;
        due_mem[wr_ptr]  <= cyc + LAT;
        wr_ptr           <= wr_ptr + 2'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      cnt <= cnt + {2'b0, push} - {2'b0, pop};
    end
  end

endmodule

//--- bench/icb_bus_sva.sv
/*
  Protocol assertions for the split controller, attached with bind.
  Checks the outstanding limit, single-target rule, response hold and the
  state right after reset.
*/

module icb_bus_sva #(
  parameter int MAX_OUTS = 2,
  parameter int CW       = 2
) (
  input logic                        clk,
  input logic                        i_rst,
  input logic                        i_cmd_valid,
  input logic [icb_fab_pkg::N_TGT:0] i_sel,
  input logic                        i_cmd_ready_sel,
  input logic                        i_rsp_valid_sel,
  input logic                        i_rsp_ready,
  input logic                        o_cmd_go,
  input logic [icb_fab_pkg::N_TGT:0] o_rsp_sel,
  input logic [CW-1:0]               outs_cnt,
  input icb_fab_pkg::split_state_e   state
);

  timeunit 1ns;
  timeprecision 100ps;

  // Target of the most recent accepted command
  logic [icb_fab_pkg::N_TGT:0] last_sel;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      last_sel <= '0;
    end else if (i_cmd_valid && i_cmd_ready_sel) begin
      last_sel <= i_sel;
    end
  end

  a_cnt_limit: assert property (@(posedge clk) disable iff (i_rst)
    outs_cnt <= CW'(MAX_OUTS))
    else $error("outstanding count above limit");

  a_full_stall: assert property (@(posedge clk) disable iff (i_rst)
    (outs_cnt == CW'(MAX_OUTS)) && !(i_rsp_valid_sel && i_rsp_ready) |-> !i_cmd_ready_sel)
    else $error("command accepted while outstanding count is full");

  // No command may pass to a second target
  a_one_target: assert property (@(posedge clk) disable iff (i_rst)
    (state == icb_fab_pkg::ST_BUSY) && i_cmd_valid && o_cmd_go |-> (i_sel == last_sel))
    else $error("command passed to a different target while busy");

  a_rsp_hold: assert property (@(posedge clk) disable iff (i_rst)
    i_rsp_valid_sel && !i_rsp_ready |=> i_rsp_valid_sel && $stable(o_rsp_sel))
    else $error("response dropped or source changed under back-pressure");

  a_after_reset: assert property (@(posedge clk)
    $fell(i_rst) |-> !i_rsp_valid_sel && !(i_cmd_valid && o_cmd_go) && (outs_cnt == '0))
    else $error("valid raised in the first cycle after reset");

endmodule

//--- bench/tb_icb_bus.sv
/*
  Testbench of the 1-to-4 bus fabric. Sends directed and LFSR-driven
  commands under random stalls, checks routing, payload and response order
  against a queue of expected responses.
*/

module tb_icb_bus;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_CMDS   = 60;
  localparam int MAX_OUTS = 2;
  localparam int LAT [4]  = '{0, 1, 3, 2};
  localparam logic [3:0][31:0] KEYS = {
    32'h0f0f_4444, 32'h5a5a_3333, 32'hc3c3_2222, 32'h9696_1111
  };

  logic clk = 1'b0;
  logic rst;
  logic [3:0] tgt_en;
  logic [3:0] stall;
  logic cmd_valid;
  logic cmd_ready;
  logic rsp_valid;
  logic rsp_ready;
  icb_fab_pkg::icb_cmd_t cmd;
  icb_fab_pkg::icb_rsp_t rsp;
  logic [3:0] tgt_cmd_valid;
  logic [3:0] tgt_cmd_ready;
  logic [3:0] tgt_rsp_valid;
  logic [3:0] tgt_rsp_ready;
  icb_fab_pkg::icb_cmd_t [3:0] tgt_cmd;
  icb_fab_pkg::icb_rsp_t [3:0] tgt_rsp;

  icb_fab_pkg::icb_rsp_t exp_q[$];
  logic [31:0] lfsr = 32'ha4b9;
  int data_errs = 0;
  int route_errs = 0;
  logic hold_q = 1'b0;
  icb_fab_pkg::icb_rsp_t rsp_q;

  always #4 clk = ~clk;

  icb_bus_1to4 #(
    .MAX_OUTS   (MAX_OUTS),
    .BASE_ADDR  ({32'h0000_4000, 32'h0000_3000, 32'h0000_2000, 32'h0000_1000}),
    .REGION_LSB ({4{8'd12}})
  ) dut_i (
    .clk (clk), .i_rst (rst), .i_tgt_en (tgt_en),
    .i_cmd_valid (cmd_valid), .o_cmd_ready (cmd_ready), .i_cmd (cmd),
    .o_rsp_valid (rsp_valid), .i_rsp_ready (rsp_ready), .o_rsp (rsp),
    .o_tgt_cmd_valid (tgt_cmd_valid), .i_tgt_cmd_ready (tgt_cmd_ready),
    .o_tgt_cmd (tgt_cmd), .i_tgt_rsp_valid (tgt_rsp_valid),
    .o_tgt_rsp_ready (tgt_rsp_ready), .i_tgt_rsp (tgt_rsp)
  );

  for (genvar t = 0; t < 4; t++) begin : g_tgt
    icb_target_model #(.LAT (LAT[t]), .KEY (KEYS[t])) tgt_i (
      .clk (clk), .i_rst (rst), .i_stall (stall[t]),
      .i_cmd_valid (tgt_cmd_valid[t]), .o_cmd_ready (tgt_cmd_ready[t]),
      .i_cmd (tgt_cmd[t]), .o_rsp_valid (tgt_rsp_valid[t]),
      .i_rsp_ready (tgt_rsp_ready[t]), .o_rsp (tgt_rsp[t])
    );
  end

  bind icb_split_ctrl icb_bus_sva #(.MAX_OUTS (MAX_OUTS), .CW (CW)) sva_i (
    .clk (clk), .i_rst (i_rst), .i_cmd_valid (i_cmd_valid), .i_sel (i_sel),
    .i_cmd_ready_sel (i_cmd_ready_sel), .i_rsp_valid_sel (i_rsp_valid_sel),
    .i_rsp_ready (i_rsp_ready), .o_cmd_go (o_cmd_go), .o_rsp_sel (o_rsp_sel),
    .outs_cnt (outs_cnt), .state (state)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    end
    return r;
  endfunction

  // Lane index 4 is the default target
  function automatic int exp_lane(input logic [31:0] addr);
    for (int t = 0; t < 4; t++) begin
      if (tgt_en[t] && addr[31:12] == 20'(t + 1)) begin
        return t;
      end
    end
    return 4;
  endfunction

  function automatic icb_fab_pkg::icb_rsp_t exp_rsp(input logic [31:0] addr);
    icb_fab_pkg::icb_rsp_t r;
    int lane;
    lane = exp_lane(addr);
    r.err   = (lane == 4);
    r.rdata = (lane == 4) ? 32'h0 : (addr ^ KEYS[lane]);
    return r;
  endfunction

  function automatic logic [31:0] pick_addr();
    logic [2:0]  reg_sel;
    logic [31:0] offs;
    reg_sel = 3'(take_bits(3));
    offs    = take_bits(12) & 32'h0000_0ffc;
    if (reg_sel < 3'd4) begin
      return ({29'd0, reg_sel} + 32'd1) * 32'h1000 + offs;
    end
    return 32'h0000_8000 + offs;
  endfunction

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic send_cmd(input logic [31:0] addr);
    cmd.addr  = addr;
    cmd.read  = 1'(take_bits(1));
    cmd.wdata = take_bits(32);
    cmd.wmask = 4'(take_bits(4));
    cmd.size  = icb_fab_pkg::SZ_WORD;
    cmd_valid = 1'b1;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    if (take_bits(1) != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // Random back-pressure from the initiator and the targets
  always @(posedge clk) begin
    #1;
    rsp_ready = (take_bits(2) != 0);
    for (int t = 0; t < 4; t++) begin
      stall[t] = (take_bits(2) == 0);
    end
  end

  ////////////////////////////////////////
  // Checks, sampled where all inputs are stable
  ////////////////////////////////////////

  always @(negedge clk) begin
    icb_fab_pkg::icb_rsp_t exp;
    int lane;
    if (!rst) begin
      lane = exp_lane(cmd.addr);
      for (int t = 0; t < 4; t++) begin
        if (tgt_cmd_valid[t]) begin
          a_route: assert (cmd_valid && t == lane) else begin
            $display("CHECK FAILED t=%0t o_tgt_cmd_valid[%0d] expected=0 actual=1",
                     $time, t);
            route_errs++;
          end
          a_payload: assert (tgt_cmd[t] == cmd) else begin
            $display("CHECK FAILED t=%0t o_tgt_cmd[%0d] expected=%h actual=%h",
                     $time, t, cmd, tgt_cmd[t]);
            data_errs++;
          end
        end
      end
      if (cmd_valid && cmd_ready) begin
        exp_q.push_back(exp_rsp(cmd.addr));
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with nothing outstanding at %0t", $time);
          route_errs++;
        end else begin
          exp = exp_q.pop_front();
          a_rsp: assert (rsp == exp) else begin
            $display("CHECK FAILED t=%0t o_rsp expected=%h actual=%h", $time, exp, rsp);
            data_errs++;
          end
        end
      end
      // A stalled response stays put into the next cycle
      if (hold_q) begin
        a_hold: assert (rsp_valid && rsp == rsp_q) else begin
          $display("CHECK FAILED t=%0t o_rsp_valid,o_rsp expected=%h actual=%h",
                   $time, {1'b1, rsp_q}, {rsp_valid, rsp});
          data_errs++;
        end
      end
      hold_q = rsp_valid && !rsp_ready;
      rsp_q  = rsp;
    end
  end

  initial begin
    #(N_CMDS * 20 * 8);
    $display("Watchdog expired before all responses returned");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    tgt_en    = 4'hf;
    stall     = '0;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // First cycle out of reset stays quiet
    @(posedge clk);
    #1;
    // Every mapped target, all enabled
    for (int t = 0; t < 4; t++) begin
      for (int k = 0; k < 3; k++) begin
        send_cmd(32'(t + 1) * 32'h1000 + (take_bits(12) & 32'h0000_0ffc));
      end
    end
    drain();
    // Disabled targets and unmapped space
    tgt_en = 4'b0101;
    repeat (8) send_cmd(pick_addr());
    drain();
    tgt_en = 4'(take_bits(4));
    repeat (8) send_cmd(pick_addr());
    drain();
    // Mixed stream under stalls
    tgt_en = 4'hf;
    repeat (32) send_cmd(pick_addr());
    drain();
    $display("Errors: %0d data, %0d routing", data_errs, route_errs);
    if (data_errs == 0 && route_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
verilog/icb_fab_pkg.sv
verilog/icb_addr_decode.sv
verilog/icb_split_ctrl.sv
verilog/icb_cmd_route.sv
verilog/icb_rsp_mux.sv
verilog/icb_bus_1to4.sv
bench/icb_target_model.sv
bench/icb_bus_sva.sv
bench/tb_icb_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fabric testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_icb_bus -f sim.f -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -q "^Test OK$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
